// File: tb.f
hw/fpga_regs_pkg.sv
hw/spi_link_pkg.sv
hw/reg_bus_if.sv
hw/spi_reg_slave.sv
hw/reg_bank.sv
hw/board_ctrl_top.sv
bench/tb_board_ctrl.sv

// File: Makefile
# verilator build of the board control testbench
TOP := tb_board_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f --Mdir obj_dir

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: bench/tb_board_ctrl.sv
// ----------------------------------------
// host spi frames on cs1 and flash pass-through on cs0
// random stimulus from a galois lfsr seeded with 72
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ns

module tb_board_ctrl;
    import fpga_regs_pkg::*;
    import spi_link_pkg::*;

    localparam int SCK_HALF = 4;   // reg_clk cycles per sck phase
    localparam int OUT_WAIT = 8;   // cycles for a control write to show

    logic                     reg_clk = 1'b0;
    logic                     rst_n_i, spi_clk_i, spi_mosi_i, spi_miso_o;
    logic [1:0]               spi_cs_i;
    logic                     qspi_miso_i, qspi_cs_o, qspi_clk_o, qspi_mosi_o;
    logic [ETH_PORTS-1:0]     mac_link_i;
    fw_word_t [ETH_PORTS-1:0] mac_rxerr_i;
    logic [1:0]               aurora_up_i;
    logic                     mdio_i, mdc_o, mdio_o, mdio_oe_o;
    logic [ETH_PORTS-1:0]     eth_phy_rst_o;

    // model of the writable registers
    logic [15:0]              lfsr;
    reg_data_t                test_sh [TEST_ARRAY_COUNT];
    logic [ETH_PORTS-1:0]     phy_rst_sh;
    logic                     mdc_sh, mdio_out_sh, mdio_dir_sh;

    always #10 reg_clk = ~reg_clk;   // 20 ns

    board_ctrl_top UUT (
        .reg_clk       (reg_clk),
        .rst_n_i       (rst_n_i),
        .spi_clk_i     (spi_clk_i),
        .spi_cs_i      (spi_cs_i),
        .spi_mosi_i    (spi_mosi_i),
        .spi_miso_o    (spi_miso_o),
        .qspi_miso_i   (qspi_miso_i),
        .qspi_cs_o     (qspi_cs_o),
        .qspi_clk_o    (qspi_clk_o),
        .qspi_mosi_o   (qspi_mosi_o),
        .mac_link_i    (mac_link_i),
        .mac_rxerr_i   (mac_rxerr_i),
        .aurora_up_i   (aurora_up_i),
        .mdio_i        (mdio_i),
        .eth_phy_rst_o (eth_phy_rst_o),
        .mdc_o         (mdc_o),
        .mdio_o        (mdio_o),
        .mdio_oe_o     (mdio_oe_o)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;   // taps 16,14,13,11
        return n;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge reg_clk);
        #2;   // drive and sample point
    endtask

    task automatic check_value(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "first error reached");
        end
    endtask

    // readback derived from the register map and the model
    function automatic reg_data_t expected_word(input reg_addr_t idx);
        reg_data_t  w;
        logic [1:0] port;
        w    = '0;
        port = 2'((idx - REG_MAC0_RXERR) >> 1);
        if (idx < REG_FW_TIME)
            w = idx[0] ? FW_DATE[31:16] : FW_DATE[15:0];
        else if (idx < REG_FW_TYPE)
            w = idx[0] ? FW_TIME[31:16] : FW_TIME[15:0];
        else if (idx == REG_FW_TYPE)
            w = FW_TYPE;
        else if (idx == REG_MAC_LINK)
            w = {12'h000, mac_link_i};
        else if (idx < REG_PHY_RST)                     // crc counters
            w = idx[0] ? mac_rxerr_i[port][31:16] : mac_rxerr_i[port][15:0];
        else if (idx == REG_PHY_RST)
            w = {12'h000, phy_rst_sh};
        else if (idx == REG_MDC)
            w = {15'h0000, mdc_sh};
        else if (idx == REG_MDIO_OUT)
            w = {15'h0000, mdio_out_sh};
        else if (idx == REG_MDIO_DIR)
            w = {15'h0000, mdio_dir_sh};
        else if (idx == REG_MDIO_IN)
            w = {15'h0000, mdio_i};
        else if (idx == REG_AURORA_STATUS)
            w = {14'h0000, aurora_up_i};
        else if (idx >= REG_TEST_ARRAY && idx < REG_TEST_ARRAY + 8'(TEST_ARRAY_COUNT))
            w = test_sh[3'(idx - REG_TEST_ARRAY)];
        return w;
    endfunction

    // ----------------------------------------
    // spi host, mode 0, cs1 selects the registers
    // ----------------------------------------
    task automatic spi_frame(input logic [7:0] addr, input reg_data_t wdata,
                             input int nbits, output reg_data_t rdata);
        logic [SPI_FRAME_BITS-1:0] tx;
        tx       = {addr, wdata};
        rdata    = '0;
        spi_cs_i = 2'b01;
        tick(SCK_HALF);
        for (int i = 0; i < nbits; i++) begin
            spi_clk_i  = 1'b0;
            spi_mosi_i = tx[SPI_FRAME_BITS-1];
            tx         = tx << 1;
            tick(SCK_HALF);
            if (i >= SPI_ADDR_BITS)
                rdata = {rdata[14:0], spi_miso_o};   // sampled just before the rise
            spi_clk_i = 1'b1;
            tick(SCK_HALF);
        end
        spi_clk_i = 1'b0;
        tick(SCK_HALF);
        spi_cs_i = 2'b11;
        tick(SCK_HALF);
    endtask

    task automatic write_reg(input reg_addr_t idx, input reg_data_t data);
        reg_data_t ignored;
        spi_frame(idx, data, SPI_FRAME_BITS, ignored);
    endtask

    task automatic check_read(input reg_addr_t idx);
        reg_data_t rd;
        spi_frame(idx + REG_RD_OFFSET, 16'h0000, SPI_FRAME_BITS, rd);
        check_value(rd, expected_word(idx), $sformatf("register 0x%02h", idx));
    endtask

    task automatic check_outputs;
        check_value(reg_data_t'(eth_phy_rst_o), reg_data_t'(phy_rst_sh), "eth_phy_rst_o");
        check_value(reg_data_t'(mdc_o), reg_data_t'(mdc_sh), "mdc_o");
        check_value(reg_data_t'(mdio_o), reg_data_t'(mdio_out_sh), "mdio_o");
        check_value(reg_data_t'(mdio_oe_o), reg_data_t'(mdio_dir_sh), "mdio_oe_o");
    endtask

    task automatic wait_outputs;
        int n;
        n = 0;
        while (({eth_phy_rst_o, mdc_o, mdio_o, mdio_oe_o}
                !== {phy_rst_sh, mdc_sh, mdio_out_sh, mdio_dir_sh}) && (n < OUT_WAIT)) begin
            tick(1);
            n++;
        end
    endtask

    // ----------------------------------------
    // sequence
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        logic [2:0]  slot;
        reg_addr_t   idx;
        reg_addr_t   ro_idx [10];
        reg_data_t   rd;

        lfsr        = 16'd72;
        ro_idx      = '{8'h00, 8'h03, 8'h04, 8'h05, 8'h06,
                        8'h0D, 8'h12, 8'h13, 8'h18, 8'h7F};
        rst_n_i     = 1'b0;
        spi_clk_i   = 1'b0;
        spi_cs_i    = 2'b11;
        spi_mosi_i  = 1'b0;
        qspi_miso_i = 1'b1;
        mac_link_i  = '0;
        mac_rxerr_i = '0;
        aurora_up_i = '0;
        mdio_i      = 1'b0;
        phy_rst_sh  = '0;
        {mdc_sh, mdio_out_sh, mdio_dir_sh} = 3'b000;
        for (int i = 0; i < TEST_ARRAY_COUNT; i++)
            test_sh[3'(i)] = '0;
        tick(2);
        rst_n_i = 1'b1;

        // reset state
        check_outputs();
        for (int i = 0; i < TEST_ARRAY_COUNT; i++)
            check_read(REG_TEST_ARRAY + 8'(i));

        // scratch array
        for (int k = 0; k < 16; k++) begin
            random_bits(3, r);
            slot = r[2:0];
            random_bits(16, r);
            write_reg(REG_TEST_ARRAY + reg_addr_t'(slot), r[15:0]);
            test_sh[slot] = r[15:0];
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++)
            check_read(REG_TEST_ARRAY + 8'(i));

        // phy reset and mdio control
        for (int k = 0; k < 12; k++) begin
            random_bits(2, r);
            idx = REG_PHY_RST + reg_addr_t'(r[1:0]);   // 0x0e to 0x11
            random_bits(16, r);
            write_reg(idx, r[15:0]);
            case (idx)
                REG_PHY_RST:  phy_rst_sh  = r[ETH_PORTS-1:0];
                REG_MDC:      mdc_sh      = r[0];
                REG_MDIO_OUT: mdio_out_sh = r[0];
                default:      mdio_dir_sh = r[0];
            endcase
            wait_outputs();
            check_outputs();
            check_read(idx);
        end

        // live status, constants and unmapped words
        random_bits(4, r);
        mac_link_i = r[3:0];
        for (int p = 0; p < ETH_PORTS; p++) begin
            random_bits(32, r);
            mac_rxerr_i[2'(p)] = r;
        end
        random_bits(3, r);
        aurora_up_i = r[1:0];
        mdio_i      = r[2];
        tick(4);                                      // mdio synchronizer
        for (int i = 0; i < 'h30; i++)
            check_read(reg_addr_t'(i));
        check_read(8'h7F);

        // short frames and read-only targets change nothing
        random_bits(16, r);
        spi_frame(REG_TEST_ARRAY + 8'd3, ~test_sh[3], 20, rd);
        spi_frame(REG_TEST_ARRAY, r[15:0], 6, rd);
        for (int i = 0; i < 10; i++) begin
            random_bits(16, r);
            write_reg(ro_idx[i], r[15:0]);
        end
        for (int i = 0; i < 'h30; i++)
            check_read(reg_addr_t'(i));
        check_outputs();

        // flash pass-through on cs0
        spi_cs_i = 2'b10;
        for (int k = 0; k < 16; k++) begin
            random_bits(3, r);
            {spi_clk_i, spi_mosi_i, qspi_miso_i} = r[2:0];
            tick(1);
            check_value(reg_data_t'(qspi_cs_o), 16'h0000, "qspi_cs_o");
            check_value(reg_data_t'(qspi_clk_o), reg_data_t'(spi_clk_i), "qspi_clk_o");
            check_value(reg_data_t'(qspi_mosi_o), reg_data_t'(spi_mosi_i), "qspi_mosi_o");
            check_value(reg_data_t'(spi_miso_o), reg_data_t'(qspi_miso_i), "spi_miso_o");
        end
        spi_clk_i = 1'b0;
        spi_cs_i  = 2'b11;
        for (int k = 0; k < 8; k++) begin
            random_bits(1, r);
            qspi_miso_i = r[0];
            tick(1);
            check_value(reg_data_t'(qspi_cs_o), 16'h0001, "qspi_cs_o idle");
            check_value(reg_data_t'(spi_miso_o), 16'h0001, "spi_miso_o idle");
        end

        $display("All tests passed!");
        $finish;
    end

endmodule : tb_board_ctrl

`default_nettype wire

// File: hw/board_ctrl_top.sv
// ----------------------------------------
// cs0 selects the config flash, cs1 the register file
// mdio is split into out, enable and in, the pad sits outside
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ns

module board_ctrl_top (
    input  logic                                                  reg_clk,
    input  logic                                                  rst_n_i,
    // host spi
    input  logic                                                  spi_clk_i,
    input  logic [1:0]                                            spi_cs_i,
    input  logic                                                  spi_mosi_i,
    output logic                                                  spi_miso_o,
    // config flash
    input  logic                                                  qspi_miso_i,
    output logic                                                  qspi_cs_o,
    output logic                                                  qspi_clk_o,
    output logic                                                  qspi_mosi_o,
    // status
    input  logic [fpga_regs_pkg::ETH_PORTS-1:0]                   mac_link_i,
    input  fpga_regs_pkg::fw_word_t [fpga_regs_pkg::ETH_PORTS-1:0] mac_rxerr_i,
    input  logic [1:0]                                            aurora_up_i,
    // phy management
    input  logic                                                  mdio_i,
    output logic [fpga_regs_pkg::ETH_PORTS-1:0]                   eth_phy_rst_o,
    output logic                                                  mdc_o,
    output logic                                                  mdio_o,
    output logic                                                  mdio_oe_o
);

    logic      reg_miso;
    reg_bus_if reg_bus ();

    spi_reg_slave u_spi_reg_slave (
        .reg_clk    (reg_clk),
        .rst_n_i    (rst_n_i),
        .spi_clk_i  (spi_clk_i),
        .spi_cs_i   (spi_cs_i[1]),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (reg_miso),
        .bus        (reg_bus.master)
    );

    reg_bank u_reg_bank (
        .reg_clk       (reg_clk),
        .rst_n_i       (rst_n_i),
        .bus           (reg_bus.slave),
        .mac_link_i    (mac_link_i),
        .mac_rxerr_i   (mac_rxerr_i),
        .aurora_up_i   (aurora_up_i),
        .mdio_i        (mdio_i),
        .eth_phy_rst_o (eth_phy_rst_o),
        .mdc_o         (mdc_o),
        .mdio_o        (mdio_o),
        .mdio_oe_o     (mdio_oe_o)
    );

    // ----------------------------------------
    // flash pass-through and miso merge
    // ----------------------------------------
    assign qspi_cs_o   = spi_cs_i[0];
    assign qspi_clk_o  = spi_clk_i;
    assign qspi_mosi_o = spi_mosi_i;

    // an unselected source reads as 1 so the and keeps the other line
    assign spi_miso_o  = (qspi_miso_i | spi_cs_i[0]) & (reg_miso | spi_cs_i[1]);

endmodule : board_ctrl_top

`default_nettype wire

// File: hw/reg_bank.sv
// ----------------------------------------
// writes land one cycle after wr_en, reads are combinational
// unmapped reads return zero, writes to read-only words are dropped
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ns

module reg_bank (
    input  logic                                                  reg_clk,
    input  logic                                                  rst_n_i,
    reg_bus_if.slave                                              bus,
    input  logic [fpga_regs_pkg::ETH_PORTS-1:0]                   mac_link_i,
    input  fpga_regs_pkg::fw_word_t [fpga_regs_pkg::ETH_PORTS-1:0] mac_rxerr_i,
    input  logic [1:0]                                            aurora_up_i,
    input  logic                                                  mdio_i,
    output logic [fpga_regs_pkg::ETH_PORTS-1:0]                   eth_phy_rst_o,
    output logic                                                  mdc_o,
    output logic                                                  mdio_o,
    output logic                                                  mdio_oe_o
);
    import fpga_regs_pkg::*;
    import spi_link_pkg::*;

    logic [ETH_PORTS-1:0] phy_rst_q;
    logic                 mdc_q;
    logic                 mdio_out_q;
    logic                 mdio_dir_q;
    reg_data_t            test_q [TEST_ARRAY_COUNT];
    logic [1:0]           mdio_sync;    // mdio pin comes from the phy domain
    reg_data_t            rd_word;

    // ----------------------------------------
    // writable registers
    // ----------------------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phy_rst_q  <= '0;
            mdc_q      <= 1'b0;
            mdio_out_q <= 1'b0;
            mdio_dir_q <= 1'b0;                 // pin released after reset
            for (int i = 0; i < TEST_ARRAY_COUNT; i++)
                test_q[i] <= '0;
        end else if (bus.wr_en) begin
            case (bus.wr_addr)
                REG_PHY_RST:  phy_rst_q  <= bus.wr_data[ETH_PORTS-1:0];
                REG_MDC:      mdc_q      <= bus.wr_data[0];
                REG_MDIO_OUT: mdio_out_q <= bus.wr_data[0];
                REG_MDIO_DIR: mdio_dir_q <= bus.wr_data[0];
                default: ;                      // read-only or unmapped
            endcase
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                if (bus.wr_addr == reg_addr_t'(REG_TEST_ARRAY + i))
                    test_q[i] <= bus.wr_data;
            end
        end
    end

    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i)
            mdio_sync <= '0;
        else
            mdio_sync <= {mdio_sync[0], mdio_i};
    end

    assign eth_phy_rst_o = phy_rst_q;
    assign mdc_o         = mdc_q;
    assign mdio_o        = mdio_out_q;
    assign mdio_oe_o     = mdio_dir_q;

    // ----------------------------------------
    // read multiplexer
    // ----------------------------------------
    always_comb begin
        rd_word = '0;
        case (bus.rd_addr)
            REG_FW_DATE:              rd_word = FW_DATE[15:0];
            REG_FW_DATE + 8'd1:       rd_word = FW_DATE[31:16];
            REG_FW_TIME:              rd_word = FW_TIME[15:0];
            REG_FW_TIME + 8'd1:       rd_word = FW_TIME[31:16];
            REG_FW_TYPE:              rd_word = FW_TYPE;
            REG_MAC_LINK:             rd_word = reg_data_t'(mac_link_i);
            REG_PHY_RST:              rd_word = reg_data_t'(phy_rst_q);
            REG_MDC:                  rd_word = reg_data_t'(mdc_q);
            REG_MDIO_OUT:             rd_word = reg_data_t'(mdio_out_q);
            REG_MDIO_DIR:             rd_word = reg_data_t'(mdio_dir_q);
            REG_MDIO_IN:              rd_word = reg_data_t'(mdio_sync[1]);
            REG_AURORA_STATUS:        rd_word = reg_data_t'(aurora_up_i);
            default: ;
        endcase
        // crc error counters, low word first
        for (int i = 0; i < ETH_PORTS; i++) begin
            if (bus.rd_addr == reg_addr_t'(REG_MAC0_RXERR + 2 * i))
                rd_word = mac_rxerr_i[i][15:0];
            if (bus.rd_addr == reg_addr_t'(REG_MAC0_RXERR + 2 * i + 1))
                rd_word = mac_rxerr_i[i][31:16];
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            if (bus.rd_addr == reg_addr_t'(REG_TEST_ARRAY + i))
                rd_word = test_q[i];
        end
    end

    assign bus.rd_data = rd_word;

    // write indices share the read numbering below the read offset
    a_wr_range: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        bus.wr_en |-> (bus.wr_addr < REG_RD_OFFSET));

endmodule : reg_bank

`default_nettype wire

// File: hw/spi_reg_slave.sv
// ----------------------------------------
// pins are oversampled in reg_clk so sck must stay at or below reg_clk/8
// a frame cut short by cs going high is dropped without a write
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ns

module spi_reg_slave (
    input  logic      reg_clk,
    input  logic      rst_n_i,
    input  logic      spi_clk_i,
    input  logic      spi_cs_i,
    input  logic      spi_mosi_i,
    output logic      spi_miso_o,
    reg_bus_if.master bus
);
    import fpga_regs_pkg::*;
    import spi_link_pkg::*;

    logic [SPI_SYNC_STAGES-1:0][2:0] pin_sync;   // {sck, cs, mosi} per stage
    logic                            sck_q;
    logic                            cs_q;
    logic                            mosi_q;
    logic                            sck_d;
    logic                            sck_rise;
    logic                            sck_fall;

    spi_state_t                      state;
    spi_bit_cnt_t                    bit_cnt;
    logic                            rd_frame;
    logic                            rd_load;

    logic [SPI_ADDR_BITS-2:0]        addr_shift;
    logic [SPI_ADDR_BITS-1:0]        addr_byte;
    logic                            addr_is_rd;
    reg_data_t                       rx_word;
    logic [SPI_DATA_BITS-1:0]        tx_shift;

    logic                            addr_rise;
    logic                            addr_done;
    logic                            data_rise;
    logic                            frame_done;
    logic                            tx_fall;

    // ----------------------------------------
    // pin synchronizer and sck edges
    // ----------------------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pin_sync <= {SPI_SYNC_STAGES{3'b010}};   // cs idles high
            sck_d    <= 1'b0;
        end else begin
            pin_sync <= {pin_sync[SPI_SYNC_STAGES-2:0], {spi_clk_i, spi_cs_i, spi_mosi_i}};
            sck_d    <= sck_q;
        end
    end

    assign sck_q    = pin_sync[SPI_SYNC_STAGES-1][2];
    assign cs_q     = pin_sync[SPI_SYNC_STAGES-1][1];
    assign mosi_q   = pin_sync[SPI_SYNC_STAGES-1][0];
    assign sck_rise = sck_q & ~sck_d;
    assign sck_fall = ~sck_q & sck_d;

    // frame strobes
    assign addr_byte  = {addr_shift, mosi_q};
    assign addr_is_rd = (addr_byte >= REG_RD_OFFSET);
    assign addr_rise  = sck_rise & ~cs_q & (state != SPI_DATA);   // first rise may meet idle
    assign addr_done  = addr_rise & (bit_cnt == spi_bit_cnt_t'(SPI_ADDR_BITS - 1));
    assign data_rise  = sck_rise & ~cs_q & (state == SPI_DATA)
                      & (bit_cnt < spi_bit_cnt_t'(SPI_FRAME_BITS));
    assign frame_done = data_rise & (bit_cnt == spi_bit_cnt_t'(SPI_FRAME_BITS - 1));
    assign tx_fall    = sck_fall & ~cs_q & (state == SPI_DATA) & rd_frame
                      & (bit_cnt < spi_bit_cnt_t'(SPI_FRAME_BITS));

    // ----------------------------------------
    // frame state
    // ----------------------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= SPI_IDLE;
            bit_cnt   <= '0;
            rd_frame  <= 1'b0;
            rd_load   <= 1'b0;
            bus.wr_en <= 1'b0;
        end else begin
            rd_load   <= addr_done & addr_is_rd;     // rd_data settles one cycle later
            bus.wr_en <= frame_done & ~rd_frame;
            if (cs_q) begin
                state    <= SPI_IDLE;                // also ends a short frame
                bit_cnt  <= '0;
                rd_frame <= 1'b0;
            end else begin
                if (addr_rise || data_rise)
                    bit_cnt <= bit_cnt + 1'b1;
                if (addr_done) begin
                    state    <= SPI_DATA;
                    rd_frame <= addr_is_rd;
                end else if (state == SPI_IDLE) begin
                    state <= SPI_ADDR;
                end
            end
        end
    end

    // shift registers and bus payload
    always_ff @(posedge reg_clk) begin
        if (addr_rise)
            addr_shift <= {addr_shift[SPI_ADDR_BITS-3:0], mosi_q};
        if (addr_done && addr_is_rd)
            bus.rd_addr <= reg_addr_t'(addr_byte - REG_RD_OFFSET);
        if (addr_done && !addr_is_rd)
            bus.wr_addr <= reg_addr_t'(addr_byte);
        if (data_rise)
            rx_word <= {rx_word[SPI_DATA_BITS-2:0], mosi_q};
        if (frame_done)
            bus.wr_data <= {rx_word[SPI_DATA_BITS-2:0], mosi_q};
    end

    // ----------------------------------------
    // miso changes after the falling sck edge
    // ----------------------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spi_miso_o <= 1'b1;
            tx_shift   <= '1;
        end else if (cs_q) begin
            spi_miso_o <= 1'b1;
        end else if (rd_load) begin
            tx_shift <= bus.rd_data;                 // latched before the first data fall
        end else if (tx_fall) begin
            spi_miso_o <= tx_shift[SPI_DATA_BITS-1];
            tx_shift   <= {tx_shift[SPI_DATA_BITS-2:0], 1'b1};
        end else if (sck_fall) begin
            spi_miso_o <= 1'b1;                      // address phase and frame tail
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_wr_single: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        bus.wr_en |=> !bus.wr_en);

    a_wr_in_frame: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        $rose(bus.wr_en) |-> !cs_q);

endmodule : spi_reg_slave

`default_nettype wire

// File: hw/reg_bus_if.sv
// ----------------------------------------
// single-cycle register port, no back-pressure
// rd_data follows rd_addr combinationally
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ns

interface reg_bus_if;
    import fpga_regs_pkg::*;

    logic      wr_en;     // one-cycle strobe
    reg_addr_t wr_addr;   // valid with wr_en
    reg_data_t wr_data;   // valid with wr_en
    reg_addr_t rd_addr;
    reg_data_t rd_data;

    modport master (
        output wr_en, wr_addr, wr_data, rd_addr,
        input  rd_data
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface : reg_bus_if

`default_nettype wire

// File: hw/spi_link_pkg.sv
// ----------------------------------------
// host spi frame: 8-bit address byte then 16-bit data word
// mode 0, msb first
// ----------------------------------------
`default_nettype none

package spi_link_pkg;

    localparam int SPI_ADDR_BITS  = 8;
    localparam int SPI_DATA_BITS  = 16;
    localparam int SPI_FRAME_BITS = 24;   // address plus data

    // address byte at or above this reads index (byte - offset)
    localparam logic [SPI_ADDR_BITS-1:0] REG_RD_OFFSET = 8'h80;

    localparam int SPI_SYNC_STAGES = 2;   // pin synchronizer depth

    typedef logic [4:0] spi_bit_cnt_t;    // bits taken in the frame

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_ADDR,
        SPI_DATA
    } spi_state_t;

endpackage : spi_link_pkg

`default_nettype wire

// File: hw/fpga_regs_pkg.sv
// ----------------------------------------
// register map of the board control block, 16-bit words
// 32-bit values take two indices, low word at the lower index
// ----------------------------------------
`default_nettype none

package fpga_regs_pkg;

    // ----------------------------------------
    // word types
    // ----------------------------------------
    typedef logic [7:0]  reg_addr_t;   // register index
    typedef logic [15:0] reg_data_t;   // register word
    typedef logic [31:0] fw_word_t;    // build stamp or crc error counter

    localparam int ETH_PORTS = 4;

    // ----------------------------------------
    // register indices
    // ----------------------------------------
    // read-only build information
    localparam reg_addr_t REG_FW_DATE       = 8'h00;   // two words
    localparam reg_addr_t REG_FW_TIME       = 8'h02;   // two words
    localparam reg_addr_t REG_FW_TYPE       = 8'h04;

    // live link status
    localparam reg_addr_t REG_MAC_LINK      = 8'h05;   // link in bits 3..0
    localparam reg_addr_t REG_MAC0_RXERR    = 8'h06;   // port n at 0x06 + 2n

    // phy management, bit-banged mdio
    localparam reg_addr_t REG_PHY_RST       = 8'h0E;   // one bit per port
    localparam reg_addr_t REG_MDC           = 8'h0F;
    localparam reg_addr_t REG_MDIO_OUT      = 8'h10;
    localparam reg_addr_t REG_MDIO_DIR      = 8'h11;   // 1 drives the mdio pin
    localparam reg_addr_t REG_MDIO_IN       = 8'h12;   // read-only

    localparam reg_addr_t REG_AURORA_STATUS = 8'h13;   // channel up, lanes 1..0

    // scratch words for host bus checks
    localparam reg_addr_t REG_TEST_ARRAY    = 8'h20;
    localparam int        TEST_ARRAY_COUNT  = 8;

    // ----------------------------------------
    // build constants
    // ----------------------------------------
    localparam fw_word_t  FW_DATE = 32'h0B1C_4E27;
    localparam fw_word_t  FW_TIME = 32'h0017_2D05;
    localparam reg_data_t FW_TYPE = 16'h0042;      // board variant code

endpackage : fpga_regs_pkg

`default_nettype wire
